/* source/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// machine widths
`define RV_XLEN       32
`define RV_REG_IDX_W  5
`define RV_NUM_REGS   32
`define RV_BYTES      4

// first fetch address after reset
`define RV_RESET_PC   32'h0000_0000

// internal data RAM size in words
`define RV_DMEM_WORDS 256

// major opcodes in insn[6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_SYSTEM  7'b1110011

// funct7 of the plain ops and of sub and sra
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

`endif

/* source/rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

  // one machine word, data or address
  typedef logic [`RV_XLEN-1:0] word_t;

  // raw instruction bits as fetched
  typedef logic [`RV_XLEN-1:0] insn_t;

  // architectural register number
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // one write enable per byte lane
  typedef logic [`RV_BYTES-1:0] byte_en_t;

  // what a pipeline slot holds in a given cycle,
  // carried with every stage down to writeback
  typedef enum logic [1:0] {
    cycle_reset        = 2'd0,
    cycle_valid        = 2'd1,
    cycle_taken_branch = 2'd2,
    cycle_load_use     = 2'd3
  } cycle_status_e;

endpackage

/* source/reg_file.sv */
`include "rv_params.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  // x0 has no storage, it is hardwired at the read ports
  rv_pkg::word_t regs [1:`RV_NUM_REGS-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero on both ports in every cycle
  assert property (@(posedge clk) disable iff (rst)
    (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
    else $error("reg_file: x0 read back nonzero");

endmodule

/* source/exec_unit.sv */
`include "rv_params.svh"

module exec_unit (
  input  rv_pkg::word_t    pc,
  input  rv_pkg::insn_t    insn,
  input  rv_pkg::word_t    op_a,
  input  rv_pkg::word_t    op_b,
  output rv_pkg::word_t    result,
  output logic             rd_we,
  output logic             illegal,
  output logic             redirect,
  output rv_pkg::word_t    redirect_pc,
  output rv_pkg::byte_en_t store_be
);

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // memory funct3, only word loads are kept
  localparam logic [2:0] f3_b    = 3'b000;
  localparam logic [2:0] f3_h    = 3'b001;
  localparam logic [2:0] f3_w    = 3'b010;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::reg_idx_t rd;

  rv_pkg::word_t imm_i, imm_s, imm_b, imm_j, imm_u;
  rv_pkg::word_t alu_b, alu_out, sra_out, addr_sum, link;
  logic [4:0]    shamt;
  logic          alu_alt;
  logic          take, br_legal;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // register-register uses rs2, everything else on the alu path uses imm_i
  assign alu_b   = (opcode == `RV_OP_REG) ? op_b : imm_i;
  assign shamt   = alu_b[4:0];
  // funct7 only selects sub for register ops, but selects sra for both formats
  assign alu_alt = (funct7 == `RV_F7_ALT) && (opcode == `RV_OP_REG || funct3 == f3_sr);
  assign sra_out = $signed(op_a) >>> shamt;

  assign addr_sum = op_a + ((opcode == `RV_OP_STORE) ? imm_s : imm_i);
  assign link     = pc + 32'd4;

  always_comb begin
    case (funct3)
      f3_add:  alu_out = alu_alt ? op_a - alu_b : op_a + alu_b;
      f3_sll:  alu_out = op_a << shamt;
      f3_slt:  alu_out = rv_pkg::word_t'($signed(op_a) < $signed(alu_b));
      f3_sltu: alu_out = rv_pkg::word_t'(op_a < alu_b);
      f3_xor:  alu_out = op_a ^ alu_b;
      f3_sr:   alu_out = alu_alt ? sra_out : op_a >> shamt;
      f3_or:   alu_out = op_a | alu_b;
      default: alu_out = op_a & alu_b;
    endcase
  end

  always_comb begin
    take     = 1'b0;
    br_legal = 1'b1;
    case (funct3)
      f3_beq:  take = (op_a == op_b);
      f3_bne:  take = (op_a != op_b);
      f3_blt:  take = ($signed(op_a) < $signed(op_b));
      f3_bge:  take = ($signed(op_a) >= $signed(op_b));
      f3_bltu: take = (op_a < op_b);
      f3_bgeu: take = (op_a >= op_b);
      default: br_legal = 1'b0;
    endcase
  end

  always_comb begin
    result      = '0;
    rd_we       = 1'b0;
    illegal     = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    store_be    = '0;
    case (opcode)
      `RV_OP_LUI: begin
        result = imm_u;
        rd_we  = 1'b1;
      end
      `RV_OP_AUIPC: begin
        result = pc + imm_u;
        rd_we  = 1'b1;
      end
      `RV_OP_JAL: begin
        result      = link;
        rd_we       = 1'b1;
        redirect    = 1'b1;
        redirect_pc = pc + imm_j;
      end
      `RV_OP_JALR: begin
        if (funct3 == 3'b000) begin
          result      = link;
          rd_we       = 1'b1;
          redirect    = 1'b1;
          redirect_pc = {addr_sum[31:1], 1'b0};
        end else begin
          illegal = 1'b1;
        end
      end
      `RV_OP_BRANCH: begin
        illegal     = !br_legal;
        redirect    = br_legal && take;
        redirect_pc = pc + imm_b;
      end
      `RV_OP_LOAD: begin
        result  = addr_sum;
        rd_we   = 1'b1;
        illegal = (funct3 != f3_w);
      end
      `RV_OP_STORE: begin
        result = addr_sum;
        case (funct3)
          f3_b:    store_be = rv_pkg::byte_en_t'(4'b0001) << addr_sum[1:0];
          f3_h:    store_be = rv_pkg::byte_en_t'(4'b0011) << {addr_sum[1], 1'b0};
          f3_w:    store_be = '1;
          default: illegal = 1'b1;
        endcase
      end
      `RV_OP_IMM: begin
        result = alu_out;
        rd_we  = 1'b1;
        if (funct3 == f3_sll) begin
          illegal = (funct7 != `RV_F7_BASE);
        end else if (funct3 == f3_sr) begin
          illegal = (funct7 != `RV_F7_BASE) && (funct7 != `RV_F7_ALT);
        end
      end
      `RV_OP_REG: begin
        result  = alu_out;
        rd_we   = 1'b1;
        illegal = !((funct7 == `RV_F7_BASE) ||
                    (funct7 == `RV_F7_ALT && (funct3 == f3_add || funct3 == f3_sr)));
      end
      `RV_OP_SYSTEM: begin
        // only ecall, which halts later in writeback
        illegal = (insn[31:7] != '0);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
    if (illegal || rd == '0) begin
      rd_we = 1'b0;
    end
  end

  // no redirect is allowed to escape from an encoding that decoded as illegal
  always_comb begin
    assert (!(redirect && illegal))
      else $error("exec_unit: redirect from illegal insn %h", insn);
  end

endmodule

/* source/hazard_unit.sv */
`include "rv_params.svh"

module hazard_unit (
  input  rv_pkg::reg_idx_t d_rs1,
  input  rv_pkg::reg_idx_t d_rs2,
  input  logic [6:0]       d_opcode,
  input  rv_pkg::reg_idx_t x_rs1,
  input  rv_pkg::reg_idx_t x_rs2,
  input  rv_pkg::reg_idx_t x_rd,
  input  logic             x_is_load,
  input  rv_pkg::reg_idx_t m_rd,
  input  logic             m_we,
  input  rv_pkg::reg_idx_t w_rd,
  input  logic             w_we,
  output logic [1:0]       fwd_a,
  output logic [1:0]       fwd_b,
  output logic             d_bypass_a,
  output logic             d_bypass_b,
  output logic             stall_load_use
);

  logic m_hit_a, m_hit_b;
  logic w_hit_a, w_hit_b;
  logic d_uses_rs2;

  // a later slot that writes rs, with x0 never counting as a producer
  function automatic logic hit(rv_pkg::reg_idx_t rd, logic we, rv_pkg::reg_idx_t rs);
    return we && (rd != '0) && (rd == rs);
  endfunction

  assign m_hit_a = hit(m_rd, m_we, x_rs1);
  assign m_hit_b = hit(m_rd, m_we, x_rs2);
  assign w_hit_a = hit(w_rd, w_we, x_rs1);
  assign w_hit_b = hit(w_rd, w_we, x_rs2);

  // bit 0 takes the memory slot, bit 1 the writeback slot
  // memory holds the younger value so it wins
  assign fwd_a = {w_hit_a && !m_hit_a, m_hit_a};
  assign fwd_b = {w_hit_b && !m_hit_b, m_hit_b};

  // writeback writes the file on the same edge decode latches its operands
  assign d_bypass_a = hit(w_rd, w_we, d_rs1);
  assign d_bypass_b = hit(w_rd, w_we, d_rs2);

  // only these formats really read rs2, elsewhere the field is immediate bits
  assign d_uses_rs2 = (d_opcode == `RV_OP_REG) ||
                      (d_opcode == `RV_OP_BRANCH) ||
                      (d_opcode == `RV_OP_STORE);

  assign stall_load_use = x_is_load && (x_rd != '0) &&
                          ((x_rd == d_rs1) || (d_uses_rs2 && x_rd == d_rs2));

endmodule

/* source/data_ram.sv */
`include "rv_params.svh"

module data_ram (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    addr,
  input  rv_pkg::byte_en_t be,
  input  rv_pkg::word_t    wdata,
  output rv_pkg::word_t    rdata
);

  localparam int idx_w = $clog2(`RV_DMEM_WORDS);

  rv_pkg::word_t    mem [`RV_DMEM_WORDS];
  logic [idx_w-1:0] idx;

  // word addressed, the low two bits pick a lane through be
  assign idx = addr[idx_w+1:2];

  // read-first, rdata returns the word as it was before this edge's write
  always_ff @(posedge clk) begin
    for (int i = 0; i < `RV_BYTES; i++) begin
      if (!rst && be[i]) begin
        mem[idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    rdata <= mem[idx];
  end

  // address bits above the index would alias onto lower words
  assert property (@(posedge clk) disable iff (rst)
    addr[`RV_XLEN-1:idx_w+2] == '0)
    else $error("data_ram: address %h beyond %0d words", addr, `RV_DMEM_WORDS);

endmodule

/* source/rv_pipeline.sv */
`include "rv_params.svh"

module rv_pipeline (
  input  logic                  clk,
  input  logic                  rst,
  output rv_pkg::word_t         imem_pc,
  input  rv_pkg::insn_t         imem_insn,
  output logic                  halt,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output logic                  trace_rd_we,
  output rv_pkg::reg_idx_t      trace_rd,
  output rv_pkg::word_t         trace_rd_data
);

  rv_pkg::word_t pc;

  // decode slot
  rv_pkg::word_t         d_pc, d_a, d_b;
  rv_pkg::insn_t         d_insn;
  rv_pkg::cycle_status_e d_status;
  rv_pkg::word_t         rf_rs1_data, rf_rs2_data;
  logic                  d_bypass_a, d_bypass_b;

  // execute slot
  rv_pkg::word_t         x_pc, x_a, x_b, x_op_a, x_op_b;
  rv_pkg::insn_t         x_insn;
  rv_pkg::cycle_status_e x_status;
  rv_pkg::word_t         x_result, x_redirect_pc;
  rv_pkg::byte_en_t      x_store_be;
  logic                  x_rd_we, x_illegal, x_redirect;
  logic [1:0]            fwd_a, fwd_b;
  logic                  stall_load_use;

  // memory slot
  rv_pkg::word_t         m_pc, m_result, m_b, m_store_src;
  rv_pkg::insn_t         m_insn;
  rv_pkg::cycle_status_e m_status;
  rv_pkg::byte_en_t      m_be;
  logic                  m_we, m_illegal, m_is_mem;
  rv_pkg::word_t         ram_addr, ram_wdata, ram_rdata;

  // writeback slot
  rv_pkg::word_t         w_pc, w_result, w_data;
  rv_pkg::insn_t         w_insn;
  rv_pkg::cycle_status_e w_status;
  logic                  w_we, w_illegal;

  // fetch, redirect takes priority over the stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (x_redirect) begin
      pc <= x_redirect_pc;
    end else if (!stall_load_use) begin
      pc <= pc + 32'd4;
    end
  end

  assign imem_pc = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pkg::cycle_reset;
    end else if (x_redirect) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pkg::cycle_taken_branch;
    end else if (!stall_load_use) begin
      d_pc     <= pc;
      d_insn   <= imem_insn;
      d_status <= rv_pkg::cycle_valid;
    end
  end

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (w_we),
    .rd       (w_insn[11:7]),
    .rd_data  (w_data),
    .rs1      (d_insn[19:15]),
    .rs2      (d_insn[24:20]),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  assign d_a = d_bypass_a ? w_data : rf_rs1_data;
  assign d_b = d_bypass_b ? w_data : rf_rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pkg::cycle_reset;
    end else if (x_redirect) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pkg::cycle_taken_branch;
    end else if (stall_load_use) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pkg::cycle_load_use;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
    end
  end

  always_ff @(posedge clk) begin
    x_a <= d_a;
    x_b <= d_b;
  end

  hazard_unit u_hazard_unit (
    .d_rs1          (d_insn[19:15]),
    .d_rs2          (d_insn[24:20]),
    .d_opcode       (d_insn[6:0]),
    .x_rs1          (x_insn[19:15]),
    .x_rs2          (x_insn[24:20]),
    .x_rd           (x_insn[11:7]),
    .x_is_load      (x_insn[6:0] == `RV_OP_LOAD),
    .m_rd           (m_insn[11:7]),
    .m_we           (m_we),
    .w_rd           (w_insn[11:7]),
    .w_we           (w_we),
    .fwd_a          (fwd_a),
    .fwd_b          (fwd_b),
    .d_bypass_a     (d_bypass_a),
    .d_bypass_b     (d_bypass_b),
    .stall_load_use (stall_load_use)
  );

  assign x_op_a = fwd_a[0] ? m_result : (fwd_a[1] ? w_data : x_a);
  assign x_op_b = fwd_b[0] ? m_result : (fwd_b[1] ? w_data : x_b);

  exec_unit u_exec_unit (
    .pc          (x_pc),
    .insn        (x_insn),
    .op_a        (x_op_a),
    .op_b        (x_op_b),
    .result      (x_result),
    .rd_we       (x_rd_we),
    .illegal     (x_illegal),
    .redirect    (x_redirect),
    .redirect_pc (x_redirect_pc),
    .store_be    (x_store_be)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc      <= '0;
      m_insn    <= '0;
      m_we      <= 1'b0;
      m_be      <= '0;
      m_illegal <= 1'b0;
      m_status  <= rv_pkg::cycle_reset;
    end else begin
      m_pc      <= x_pc;
      m_insn    <= x_insn;
      m_we      <= x_rd_we;
      m_be      <= x_store_be;
      // bubbles carry insn 0, which decodes as illegal
      m_illegal <= x_illegal && (x_status == rv_pkg::cycle_valid);
      m_status  <= x_status;
    end
  end

  always_ff @(posedge clk) begin
    m_result <= x_result;
    m_b      <= x_op_b;
  end

  // store data from the older insn now in writeback
  assign m_store_src = (w_we && w_insn[11:7] != '0 && w_insn[11:7] == m_insn[24:20]) ?
                       w_data : m_b;

  // replicate into every lane, be picks the ones that land
  always_comb begin
    case (m_be)
      4'b0011, 4'b1100: ram_wdata = {2{m_store_src[15:0]}};
      4'b1111:          ram_wdata = m_store_src;
      default:          ram_wdata = {4{m_store_src[7:0]}};
    endcase
  end

  assign m_is_mem = (m_insn[6:0] == `RV_OP_LOAD) || (m_insn[6:0] == `RV_OP_STORE);
  assign ram_addr = m_is_mem ? m_result : '0;

  data_ram u_data_ram (
    .clk   (clk),
    .rst   (rst),
    .addr  (ram_addr),
    .be    (m_be),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc      <= '0;
      w_insn    <= '0;
      w_we      <= 1'b0;
      w_illegal <= 1'b0;
      w_status  <= rv_pkg::cycle_reset;
    end else begin
      w_pc      <= m_pc;
      w_insn    <= m_insn;
      w_we      <= m_we;
      w_illegal <= m_illegal;
      w_status  <= m_status;
    end
  end

  always_ff @(posedge clk) begin
    w_result <= m_result;
  end

  // ram read data lines up with the load now in writeback
  assign w_data = (w_insn[6:0] == `RV_OP_LOAD) ? ram_rdata : w_result;

  assign halt = (w_status == rv_pkg::cycle_valid) &&
                (w_insn[6:0] == `RV_OP_SYSTEM) && (w_insn[31:7] == '0);

  assign trace_pc      = w_illegal ? '0 : w_pc;
  assign trace_insn    = w_illegal ? '0 : w_insn;
  assign trace_status  = w_status;
  assign trace_rd_we   = w_we;
  assign trace_rd      = w_insn[11:7];
  assign trace_rd_data = w_data;

  // a load in execute never redirects, so the stall and redirect stay disjoint
  assert property (@(posedge clk) disable iff (rst) !(x_redirect && stall_load_use))
    else $error("rv_pipeline: redirect and load-use stall in the same cycle");

endmodule

/* dv/rv_pipeline_tb.sv */
`include "rv_params.svh"

module rv_pipeline_tb;

  localparam int num_tests  = 5;
  localparam int max_words  = 12;
  localparam int max_writes = 12;

  // alu and branch funct3 codes
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bgeu = 3'b111;
  localparam logic [2:0] f3_byte = 3'b000;
  localparam logic [2:0] f3_half = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;

  localparam logic [31:0] ecall_insn = {25'd0, `RV_OP_SYSTEM};

  logic clk = 1'b0;
  logic rst = 1'b1;

  rv_pkg::word_t         imem_pc;
  rv_pkg::insn_t         imem_insn;
  logic                  halt;
  rv_pkg::word_t         trace_pc;
  rv_pkg::insn_t         trace_insn;
  rv_pkg::cycle_status_e trace_status;
  logic                  trace_rd_we;
  rv_pkg::reg_idx_t      trace_rd;
  rv_pkg::word_t         trace_rd_data;

  // test table, one row per program
  logic [31:0] prog [num_tests][max_words];
  int          prog_len [num_tests];
  logic [4:0]  exp_rd [num_tests][max_writes];
  logic [31:0] exp_val [num_tests][max_writes];
  int          exp_writes [num_tests];
  int          exp_taken [num_tests];
  int          exp_load_use [num_tests];
  int          exp_illegal [num_tests];
  string       test_name [num_tests];

  int          cur = 0;
  int          fetch_idx;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [4:0]  got_rd [$];
  logic [31:0] got_val [$];

  always #10 clk = ~clk;

  rv_pipeline u_rv_pipeline (
    .clk           (clk),
    .rst           (rst),
    .imem_pc       (imem_pc),
    .imem_insn     (imem_insn),
    .halt          (halt),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_rd_we   (trace_rd_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

  // instruction memory, anything past the program fetches ecall
  always_comb begin
    fetch_idx = int'(imem_pc >> 2);
    if (fetch_idx < prog_len[cur]) begin
      imem_insn = prog[cur][fetch_idx];
    end else begin
      imem_insn = ecall_insn;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  task automatic add_insn(input int t, input logic [31:0] w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  task automatic add_write(input int t, input logic [4:0] rd, input logic [31:0] v);
    exp_rd[t][exp_writes[t]]  = rd;
    exp_val[t][exp_writes[t]] = v;
    exp_writes[t]++;
  endtask

  task automatic build_table();
    for (int t = 0; t < num_tests; t++) begin
      prog_len[t]     = 0;
      exp_writes[t]   = 0;
      exp_taken[t]    = 0;
      exp_load_use[t] = 0;
      exp_illegal[t]  = 0;
    end
    // each op reads the one before it, through memory, writeback and decode bypass
    test_name[0] = "alu chain";
    add_insn(0, enc_i(12'd5, 5'd0, f3_add, 5'd1, `RV_OP_IMM));
    add_insn(0, enc_r(`RV_F7_BASE, 5'd1, 5'd1, f3_add, 5'd2));
    add_insn(0, enc_r(`RV_F7_ALT, 5'd1, 5'd2, f3_add, 5'd3));
    add_insn(0, enc_r(`RV_F7_BASE, 5'd2, 5'd3, f3_xor, 5'd4));
    add_insn(0, enc_r(`RV_F7_BASE, 5'd1, 5'd4, f3_sll, 5'd5));
    add_insn(0, enc_r(`RV_F7_ALT, 5'd5, 5'd0, f3_add, 5'd6));
    add_insn(0, enc_r(`RV_F7_ALT, 5'd3, 5'd6, f3_sr, 5'd7));
    add_insn(0, enc_r(`RV_F7_BASE, 5'd7, 5'd5, f3_add, 5'd8));
    add_insn(0, enc_r(`RV_F7_BASE, 5'd1, 5'd8, f3_or, 5'd9));
    add_insn(0, enc_i(12'h0F0, 5'd9, f3_and, 5'd10, `RV_OP_IMM));
    add_write(0, 5'd1, 32'd5);
    add_write(0, 5'd2, 32'd10);
    add_write(0, 5'd3, 32'd5);
    add_write(0, 5'd4, 32'd15);
    add_write(0, 5'd5, 32'h0000_01E0);
    add_write(0, 5'd6, 32'hFFFF_FE20);
    add_write(0, 5'd7, 32'hFFFF_FFF1);
    add_write(0, 5'd8, 32'h0000_01D1);
    add_write(0, 5'd9, 32'h0000_01D5);
    add_write(0, 5'd10, 32'h0000_00D0);

    test_name[1] = "upper immediates and compares";
    add_insn(1, enc_u(20'h80000, 5'd1, `RV_OP_LUI));
    add_insn(1, enc_u(20'h00001, 5'd2, `RV_OP_AUIPC));
    add_insn(1, enc_r(`RV_F7_BASE, 5'd2, 5'd1, f3_slt, 5'd3));
    add_insn(1, enc_r(`RV_F7_BASE, 5'd2, 5'd1, f3_sltu, 5'd4));
    add_insn(1, enc_i(12'hFFF, 5'd1, f3_slt, 5'd5, `RV_OP_IMM));
    add_insn(1, enc_i(12'hFFF, 5'd2, f3_sltu, 5'd6, `RV_OP_IMM));
    add_insn(1, enc_u(20'hFFFFF, 5'd7, `RV_OP_AUIPC));
    add_write(1, 5'd1, 32'h8000_0000);
    add_write(1, 5'd2, 32'h0000_1004);
    add_write(1, 5'd3, 32'd1);
    add_write(1, 5'd4, 32'd0);
    add_write(1, 5'd5, 32'd1);
    add_write(1, 5'd6, 32'd1);
    add_write(1, 5'd7, 32'hFFFF_F018);

    // every skipped addi targets x3, so any write to x3 is an error
    test_name[2] = "branches and jumps";
    add_insn(2, enc_i(12'd3, 5'd0, f3_add, 5'd1, `RV_OP_IMM));
    add_insn(2, enc_i(12'hFFF, 5'd0, f3_add, 5'd2, `RV_OP_IMM));
    add_insn(2, enc_b(13'd8, 5'd1, 5'd1, f3_beq));
    add_insn(2, enc_i(12'd99, 5'd0, f3_add, 5'd3, `RV_OP_IMM));
    add_insn(2, enc_b(13'd8, 5'd1, 5'd1, f3_bne));
    add_insn(2, enc_b(13'd8, 5'd1, 5'd2, f3_blt));
    add_insn(2, enc_i(12'd77, 5'd0, f3_add, 5'd3, `RV_OP_IMM));
    add_insn(2, enc_b(13'd8, 5'd2, 5'd1, f3_bgeu));
    add_insn(2, enc_j(21'd8, 5'd4));
    add_insn(2, enc_i(12'd55, 5'd0, f3_add, 5'd3, `RV_OP_IMM));
    add_insn(2, enc_i(12'd13, 5'd4, f3_add, 5'd5, `RV_OP_JALR));
    add_insn(2, enc_i(12'd33, 5'd0, f3_add, 5'd3, `RV_OP_IMM));
    add_write(2, 5'd1, 32'd3);
    add_write(2, 5'd2, 32'hFFFF_FFFF);
    add_write(2, 5'd4, 32'd36);
    add_write(2, 5'd5, 32'd44);
    exp_taken[2] = 8;

    test_name[3] = "stores, load and load-use";
    add_insn(3, enc_u(20'h12345, 5'd1, `RV_OP_LUI));
    add_insn(3, enc_i(12'h678, 5'd1, f3_add, 5'd1, `RV_OP_IMM));
    add_insn(3, enc_i(12'h040, 5'd0, f3_add, 5'd2, `RV_OP_IMM));
    add_insn(3, enc_s(12'd0, 5'd1, 5'd2, f3_word));
    add_insn(3, enc_i(12'hBEE, 5'd0, f3_add, 5'd3, `RV_OP_IMM));
    add_insn(3, enc_s(12'd2, 5'd3, 5'd2, f3_half));
    add_insn(3, enc_i(12'h0CD, 5'd0, f3_add, 5'd4, `RV_OP_IMM));
    add_insn(3, enc_s(12'd1, 5'd4, 5'd2, f3_byte));
    add_insn(3, enc_i(12'd0, 5'd2, f3_word, 5'd5, `RV_OP_LOAD));
    add_insn(3, enc_r(`RV_F7_BASE, 5'd1, 5'd5, f3_add, 5'd6));
    add_write(3, 5'd1, 32'h1234_5000);
    add_write(3, 5'd1, 32'h1234_5678);
    add_write(3, 5'd2, 32'h0000_0040);
    add_write(3, 5'd3, 32'hFFFF_FBEE);
    add_write(3, 5'd4, 32'h0000_00CD);
    add_write(3, 5'd5, 32'hFBEE_CD78);
    add_write(3, 5'd6, 32'h0E23_23F0);
    exp_load_use[3] = 1;

    // a nop first puts the illegal word at a nonzero pc
    test_name[4] = "illegal word then ecall";
    add_insn(4, enc_i(12'd0, 5'd0, f3_add, 5'd0, `RV_OP_IMM));
    add_insn(4, 32'hFFFF_FFFF);
    add_insn(4, ecall_insn);
    exp_illegal[4] = 1;

    for (int t = 0; t < num_tests; t++) begin
      cycle_limit += 20 * prog_len[t] + 40;
    end
  endtask

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  task automatic run_test(input int t);
    int taken;
    int load_use;
    int illegal_slots;
    int errors_before;
    bit halted;
    taken         = 0;
    load_use      = 0;
    illegal_slots = 0;
    errors_before = errors;
    halted        = 1'b0;
    got_rd.delete();
    got_val.delete();
    @(posedge clk);
    cur <= t;
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // writeback outputs are registered, so look at them mid-cycle
    while (!halted) begin
      @(negedge clk);
      if (trace_rd_we) begin
        got_rd.push_back(trace_rd);
        got_val.push_back(trace_rd_data);
      end
      if (trace_status == rv_pkg::cycle_taken_branch) begin
        taken++;
      end
      if (trace_status == rv_pkg::cycle_load_use) begin
        load_use++;
      end
      if (trace_status == rv_pkg::cycle_valid && trace_insn == '0) begin
        illegal_slots++;
        check_value("trace_pc", 32'h0, trace_pc);
      end
      halted = halt;
    end
    if (got_rd.size() != exp_writes[t]) begin
      $display("test %0d saw %0d register writes where %0d were expected",
               t, got_rd.size(), exp_writes[t]);
      errors++;
    end
    for (int i = 0; i < exp_writes[t] && i < got_rd.size(); i++) begin
      check_value("trace_rd", 32'(exp_rd[t][i]), 32'(got_rd[i]));
      check_value("trace_rd_data", exp_val[t][i], got_val[i]);
    end
    check_value("trace_status taken-branch count", exp_taken[t], taken);
    check_value("trace_status load-use count", exp_load_use[t], load_use);
    check_value("trace_insn illegal slot count", exp_illegal[t], illegal_slots);
    if (errors == errors_before) begin
      passed++;
      $display("test %0d %s: ok", t, test_name[t]);
    end else begin
      failed++;
      $display("test %0d %s: %0d errors", t, test_name[t], errors - errors_before);
    end
  endtask

  initial begin
    build_table();
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_tests, passed, failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+source
source/rv_pkg.sv
source/reg_file.sv
source/exec_unit.sv
source/hazard_unit.sv
source/data_ram.sv
source/rv_pipeline.sv
dv/rv_pipeline_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rv_pipeline_tb -f tb.f -o rv_sim > build.log 2>&1 \
  && ./obj_dir/rv_sim > sim.log 2>&1 \
  && grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
